// File: perf_pkg.sv
package perf_pkg;

	// AXI4-Lite data word, counts are zero-extended into it
	typedef logic [31:0] word_t;

	// byte address of the register space
	typedef logic [7:0] addr_t;

	// only the two response codes the slave ever returns
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_t;

	// counter index, also the word index in the register map
	typedef enum logic [2:0]
	{
		EV_BRANCH  = 3'd0,
		EV_BR_MISP = 3'd1,
		EV_IC_HIT  = 3'd2,
		EV_IC_MISS = 3'd3,
		EV_DC_HIT  = 3'd4,
		EV_DC_MISS = 3'd5,
		EV_L2_HIT  = 3'd6,
		EV_L2_MISS = 3'd7
	} event_id_t;

	localparam int NUM_EVENTS = 8;

	// counters at 4*i for 0x00..0x1c, control right after them
	localparam addr_t CTRL_OFFSET = 8'h20;

	// control register fields
	localparam int CTRL_ENABLE_BIT = 0;

endpackage : perf_pkg

// File: perf_event_counter.sv
`timescale 1ns/1ns

module perf_event_counter
#(
	parameter int COUNT_WIDTH = 16
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   clear,
	input  logic                   increment,
	output logic [COUNT_WIDTH-1:0] count
);

	logic [COUNT_WIDTH-1:0] value;

	// clear has priority over a same-cycle increment
	always_ff @(posedge clk)
	begin
		if (reset || clear)
			value <= '0;
		else if (increment)
			// wraps from all ones back to zero
			value <= value + 1'b1;
	end

	assign count = value;

	// a cleared counter must read zero one cycle later
	clear_zeroes_count: assert property (
		@(posedge clk) clear |=> (count == '0)
	);

endmodule : perf_event_counter

// File: perf_event_qualify.sv
`timescale 1ns/1ns

module perf_event_qualify
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            count_enable,
	input  logic                            br_issue,
	input  logic                            br_mispredict,
	input  logic                            stall,
	input  logic                            icache_hit,
	input  logic                            icache_miss,
	input  logic                            dcache_hit,
	input  logic                            dcache_miss,
	input  logic                            l2_hit,
	input  logic                            l2_miss,
	output logic [perf_pkg::NUM_EVENTS-1:0] inc
);

	// combinational so an event at edge t lands in the count at edge t
	always_comb
	begin
		inc = '0;
		// a stalled branch stays in place, count it only once it moves
		inc[perf_pkg::EV_BRANCH]  = br_issue && !stall;
		inc[perf_pkg::EV_BR_MISP] = br_issue && br_mispredict && !stall;
		// cache strobes are one pulse per access, stall or not
		inc[perf_pkg::EV_IC_HIT]  = icache_hit;
		inc[perf_pkg::EV_IC_MISS] = icache_miss;
		inc[perf_pkg::EV_DC_HIT]  = dcache_hit;
		inc[perf_pkg::EV_DC_MISS] = dcache_miss;
		inc[perf_pkg::EV_L2_HIT]  = l2_hit;
		inc[perf_pkg::EV_L2_MISS] = l2_miss;
		// global stop from the control register
		if (!count_enable)
			inc = '0;
	end

	// the processor resolves a mispredict only on an issued branch
	mispredict_needs_issue: assert property (
		@(posedge clk) disable iff (reset) br_mispredict |-> br_issue
	);

endmodule : perf_event_qualify

// File: perf_counter_bank.sv
`timescale 1ns/1ns

module perf_counter_bank
#(
	parameter int COUNT_WIDTH = 16
)
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic [perf_pkg::NUM_EVENTS-1:0] inc,
	input  logic                            clear_valid,
	input  perf_pkg::event_id_t             clear_id,
	input  perf_pkg::event_id_t             read_id,
	output perf_pkg::word_t                 read_count
);

	logic [perf_pkg::NUM_EVENTS-1:0] clear_line;
	logic [COUNT_WIDTH-1:0]          counts [perf_pkg::NUM_EVENTS];

	// one-hot clear, at most one counter per bus write
	always_comb
	begin
		clear_line = '0;
		if (clear_valid)
			clear_line[clear_id] = 1'b1;
	end

	// one counter per event, index matches event_id_t
	for (genvar i = 0; i < perf_pkg::NUM_EVENTS; i++)
	begin : g_counter
		perf_event_counter
		#(
			.COUNT_WIDTH (COUNT_WIDTH)
		)
		counter_i
		(
			.clk       (clk),
			.reset     (reset),
			.clear     (clear_line[i]),
			.increment (inc[i]),
			.count     (counts[i])
		);
	end

	// read-out mux, upper bits stay zero
	always_comb
	begin
		read_count = '0;
		read_count[COUNT_WIDTH-1:0] = counts[read_id];
	end

endmodule : perf_counter_bank

// File: perf_axil_fsm.sv
`timescale 1ns/1ns

module perf_axil_fsm
(
	input  logic                 clk,
	input  logic                 reset,
	// write address and data
	input  perf_pkg::addr_t      awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  perf_pkg::word_t      wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	// write response
	output perf_pkg::axil_resp_t bresp,
	output logic                 bvalid,
	input  logic                 bready,
	// read address
	input  perf_pkg::addr_t      araddr,
	input  logic                 arvalid,
	output logic                 arready,
	// read data
	output perf_pkg::word_t      rdata,
	output perf_pkg::axil_resp_t rresp,
	output logic                 rvalid,
	input  logic                 rready,
	// towards qualifier and counter bank
	output logic                 count_enable,
	output logic                 clear_valid,
	output perf_pkg::event_id_t  clear_id,
	output perf_pkg::event_id_t  read_id,
	input  perf_pkg::word_t      read_count
);

	typedef enum logic {W_IDLE, W_RESP} wr_state_t;
	typedef enum logic {R_IDLE, R_RESP} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic      wr_accept;
	logic      rd_accept;
	logic      wr_is_counter;
	logic      wr_is_ctrl;
	logic      rd_is_counter;
	logic      rd_is_ctrl;

	// word-aligned address below the control register
	function automatic logic is_counter_addr(perf_pkg::addr_t addr);
		return (addr < perf_pkg::CTRL_OFFSET) && (addr[1:0] == 2'b00);
	endfunction

	assign wr_is_counter = is_counter_addr(awaddr);
	assign wr_is_ctrl    = (awaddr == perf_pkg::CTRL_OFFSET);
	assign rd_is_counter = is_counter_addr(araddr);
	assign rd_is_ctrl    = (araddr == perf_pkg::CTRL_OFFSET);

	// address and data are taken in the same cycle
	assign wr_accept = (wr_state == W_IDLE) && awvalid && wvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;
	assign bvalid    = (wr_state == W_RESP);

	assign arready   = (rd_state == R_IDLE);
	assign rd_accept = arready && arvalid;
	assign rvalid    = (rd_state == R_RESP);

	// clear hits the counter on the accept edge
	assign clear_valid = wr_accept && wr_is_counter;
	assign clear_id    = perf_pkg::event_id_t'(awaddr[4:2]);
	assign read_id     = perf_pkg::event_id_t'(araddr[4:2]);

	// write channel
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_state     <= W_IDLE;
			count_enable <= 1'b1;
		end
		else if (wr_accept)
		begin
			wr_state <= W_RESP;
			if (wr_is_ctrl && wstrb[0])
				count_enable <= wdata[perf_pkg::CTRL_ENABLE_BIT];
		end
		else if (bvalid && bready)
			wr_state <= W_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (wr_accept)
			bresp <= (wr_is_counter || wr_is_ctrl) ? perf_pkg::OKAY : perf_pkg::SLVERR;
	end

	// read channel
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_state <= R_IDLE;
		else if (rd_accept)
			rd_state <= R_RESP;
		else if (rvalid && rready)
			rd_state <= R_IDLE;
	end

	// data and response frozen at acceptance
	always_ff @(posedge clk)
	begin
		if (rd_accept)
		begin
			rresp <= perf_pkg::OKAY;
			rdata <= '0;
			if (rd_is_counter)
				rdata <= read_count;
			else if (rd_is_ctrl)
				rdata[perf_pkg::CTRL_ENABLE_BIT] <= count_enable;
			else
				rresp <= perf_pkg::SLVERR;
		end
	end

	bvalid_holds: assert property (
		@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid
	);

	rvalid_holds: assert property (
		@(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid
	);

endmodule : perf_axil_fsm

// File: perf_monitor_top.sv
`timescale 1ns/1ns

module perf_monitor_top
#(
	parameter int COUNT_WIDTH = 16
)
(
	input  logic                 clk,
	input  logic                 reset,
	// processor and cache strobes
	input  logic                 br_issue,
	input  logic                 br_mispredict,
	input  logic                 stall,
	input  logic                 icache_hit,
	input  logic                 icache_miss,
	input  logic                 dcache_hit,
	input  logic                 dcache_miss,
	input  logic                 l2_hit,
	input  logic                 l2_miss,
	// AXI4-Lite slave
	input  perf_pkg::addr_t      awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  perf_pkg::word_t      wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output perf_pkg::axil_resp_t bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  perf_pkg::addr_t      araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output perf_pkg::word_t      rdata,
	output perf_pkg::axil_resp_t rresp,
	output logic                 rvalid,
	input  logic                 rready
);

	logic [perf_pkg::NUM_EVENTS-1:0] inc;
	logic                            count_enable;
	logic                            clear_valid;
	perf_pkg::event_id_t             clear_id;
	perf_pkg::event_id_t             read_id;
	perf_pkg::word_t                 read_count;

	perf_event_qualify qualify_i
	(
		.clk           (clk),
		.reset         (reset),
		.count_enable  (count_enable),
		.br_issue      (br_issue),
		.br_mispredict (br_mispredict),
		.stall         (stall),
		.icache_hit    (icache_hit),
		.icache_miss   (icache_miss),
		.dcache_hit    (dcache_hit),
		.dcache_miss   (dcache_miss),
		.l2_hit        (l2_hit),
		.l2_miss       (l2_miss),
		.inc           (inc)
	);

	perf_counter_bank
	#(
		.COUNT_WIDTH (COUNT_WIDTH)
	)
	bank_i
	(
		.clk         (clk),
		.reset       (reset),
		.inc         (inc),
		.clear_valid (clear_valid),
		.clear_id    (clear_id),
		.read_id     (read_id),
		.read_count  (read_count)
	);

	perf_axil_fsm fsm_i
	(
		.clk          (clk),
		.reset        (reset),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.count_enable (count_enable),
		.clear_valid  (clear_valid),
		.clear_id     (clear_id),
		.read_id      (read_id),
		.read_count   (read_count)
	);

endmodule : perf_monitor_top

// File: perf_monitor_tb.sv
`timescale 1ns/1ns

module perf_monitor_tb;

	localparam int COUNT_WIDTH = 8;
	localparam int TIMEOUT     = 100;

	logic                 clk;
	logic                 reset;
	logic                 br_issue;
	logic                 br_mispredict;
	logic                 stall;
	logic                 icache_hit;
	logic                 icache_miss;
	logic                 dcache_hit;
	logic                 dcache_miss;
	logic                 l2_hit;
	logic                 l2_miss;
	perf_pkg::addr_t      awaddr;
	logic                 awvalid;
	logic                 awready;
	perf_pkg::word_t      wdata;
	logic [3:0]           wstrb;
	logic                 wvalid;
	logic                 wready;
	perf_pkg::axil_resp_t bresp;
	logic                 bvalid;
	logic                 bready;
	perf_pkg::addr_t      araddr;
	logic                 arvalid;
	logic                 arready;
	perf_pkg::word_t      rdata;
	perf_pkg::axil_resp_t rresp;
	logic                 rvalid;
	logic                 rready;

	int seed = 21;
	int checks;
	int errors;
	int timeouts;
	// expected counts kept unbounded and wrapped on compare
	int unsigned model [perf_pkg::NUM_EVENTS];
	bit model_enable;

	perf_monitor_top #(.COUNT_WIDTH (COUNT_WIDTH)) perf_monitor_top_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic perf_pkg::word_t expected_count(input int i);
		return perf_pkg::word_t'(model[i] % (32'd1 << COUNT_WIDTH));
	endfunction

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout: %s within %0d cycles", what, TIMEOUT);
	endtask

	task automatic check_word(input string label, input perf_pkg::word_t expected,
		input perf_pkg::word_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL %s: expected 0x%08h, actual 0x%08h", label, expected, actual);
		end
	endtask

	task automatic check_resp(input string label, input perf_pkg::axil_resp_t expected,
		input perf_pkg::axil_resp_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL %s: expected %s, actual %s (%b)", label, expected.name(),
				actual.name(), actual);
		end
	endtask

	task automatic axil_write(input perf_pkg::addr_t addr, input perf_pkg::word_t data,
		output perf_pkg::axil_resp_t resp);
		int wait_cycles;
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		wait_cycles = 0;
		// readies are combinational so look at them mid-cycle
		@(negedge clk);
		while (!(awready && wready) && wait_cycles < TIMEOUT)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!(awready && wready))
			report_timeout("write address and data not accepted");
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		wait_cycles = 0;
		@(negedge clk);
		while (!bvalid && wait_cycles < TIMEOUT)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!bvalid)
			report_timeout("no write response");
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input perf_pkg::addr_t addr, output perf_pkg::word_t data,
		output perf_pkg::axil_resp_t resp);
		int wait_cycles;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		wait_cycles = 0;
		@(negedge clk);
		while (!arready && wait_cycles < TIMEOUT)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!arready)
			report_timeout("read address not accepted");
		@(posedge clk);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		wait_cycles = 0;
		@(negedge clk);
		while (!rvalid && wait_cycles < TIMEOUT)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!rvalid)
			report_timeout("no read data");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic read_and_check(input string label, input perf_pkg::addr_t addr,
		input perf_pkg::word_t exp_data, input perf_pkg::axil_resp_t exp_resp);
		perf_pkg::word_t      data;
		perf_pkg::axil_resp_t resp;
		axil_read(addr, data, resp);
		check_resp({label, " rresp"}, exp_resp, resp);
		check_word({label, " rdata"}, exp_data, data);
	endtask

	task automatic check_all_counters(input string label);
		for (int i = 0; i < perf_pkg::NUM_EVENTS; i++)
			read_and_check($sformatf("%s counter %0d", label, i), perf_pkg::addr_t'(4 * i),
				expected_count(i), perf_pkg::OKAY);
	endtask

	// one cache strobe held high for a number of cycles
	task automatic pulse_event(input perf_pkg::event_id_t id, input int cycles);
		@(posedge clk);
		case (id)
			perf_pkg::EV_IC_HIT:  icache_hit  <= 1'b1;
			perf_pkg::EV_IC_MISS: icache_miss <= 1'b1;
			perf_pkg::EV_DC_HIT:  dcache_hit  <= 1'b1;
			perf_pkg::EV_DC_MISS: dcache_miss <= 1'b1;
			perf_pkg::EV_L2_HIT:  l2_hit      <= 1'b1;
			perf_pkg::EV_L2_MISS: l2_miss     <= 1'b1;
			default:
			begin
				errors++;
				$display("pulse_event was given %s, which is not a cache event", id.name());
			end
		endcase
		repeat (cycles) @(posedge clk);
		icache_hit  <= 1'b0;
		icache_miss <= 1'b0;
		dcache_hit  <= 1'b0;
		dcache_miss <= 1'b0;
		l2_hit      <= 1'b0;
		l2_miss     <= 1'b0;
		if (model_enable)
			model[int'(id)] += cycles;
	endtask

	// random mix of issue, stall and mispredict with one choice per cycle
	task automatic drive_branches(input int cycles);
		logic issue;
		logic stalled;
		logic misp;
		repeat (cycles)
		begin
			issue   = 1'($random(seed));
			stalled = (($random(seed) & 3) == 0);
			misp    = issue && 1'($random(seed));
			@(posedge clk);
			br_issue      <= issue;
			br_mispredict <= misp;
			stall         <= stalled;
			if (model_enable && issue && !stalled)
			begin
				model[perf_pkg::EV_BRANCH]++;
				if (misp)
					model[perf_pkg::EV_BR_MISP]++;
			end
		end
		@(posedge clk);
		br_issue      <= 1'b0;
		br_mispredict <= 1'b0;
		stall         <= 1'b0;
	endtask

	task automatic check_reset_values();
		check_all_counters("reset");
		read_and_check("reset control", perf_pkg::CTRL_OFFSET, 32'd1, perf_pkg::OKAY);
	endtask

	task automatic count_cache_events();
		perf_pkg::event_id_t id;
		for (int i = int'(perf_pkg::EV_IC_HIT); i <= int'(perf_pkg::EV_L2_MISS); i++)
		begin
			id = perf_pkg::event_id_t'(i);
			// hits are pulsed under a stall and misses without one
			@(posedge clk);
			stall <= (i % 2 == 0);
			pulse_event(id, rand_range(1, 40));
			@(posedge clk);
			stall <= 1'b0;
			check_all_counters($sformatf("cache %s", id.name()));
		end
	endtask

	task automatic count_branches();
		drive_branches(80);
		check_all_counters("branch");
	endtask

	task automatic clear_one_counter();
		perf_pkg::axil_resp_t resp;
		axil_write(perf_pkg::addr_t'(4 * perf_pkg::EV_IC_MISS), 32'h0, resp);
		check_resp("clear bresp", perf_pkg::OKAY, resp);
		model[perf_pkg::EV_IC_MISS] = 0;
		check_all_counters("clear");
	endtask

	task automatic toggle_enable();
		perf_pkg::axil_resp_t resp;
		axil_write(perf_pkg::CTRL_OFFSET, 32'h0, resp);
		check_resp("disable bresp", perf_pkg::OKAY, resp);
		model_enable = 1'b0;
		read_and_check("disabled control", perf_pkg::CTRL_OFFSET, 32'd0, perf_pkg::OKAY);
		for (int i = int'(perf_pkg::EV_IC_HIT); i <= int'(perf_pkg::EV_L2_MISS); i++)
			pulse_event(perf_pkg::event_id_t'(i), rand_range(1, 10));
		drive_branches(20);
		check_all_counters("disabled");
		axil_write(perf_pkg::CTRL_OFFSET, 32'h1, resp);
		check_resp("enable bresp", perf_pkg::OKAY, resp);
		model_enable = 1'b1;
		read_and_check("enabled control", perf_pkg::CTRL_OFFSET, 32'd1, perf_pkg::OKAY);
		pulse_event(perf_pkg::EV_L2_HIT, rand_range(1, 40));
		drive_branches(20);
		check_all_counters("enabled");
	endtask

	task automatic unmapped_and_wrap();
		perf_pkg::axil_resp_t resp;
		axil_write(8'h24, 32'h0, resp);
		check_resp("unmapped write bresp", perf_pkg::SLVERR, resp);
		// unaligned so not counter 1
		axil_write(8'h06, 32'h0, resp);
		check_resp("unaligned write bresp", perf_pkg::SLVERR, resp);
		read_and_check("unmapped read", 8'h24, 32'd0, perf_pkg::SLVERR);
		read_and_check("unmapped high read", 8'hfc, 32'd0, perf_pkg::SLVERR);
		check_all_counters("unmapped");
		axil_write(perf_pkg::addr_t'(4 * perf_pkg::EV_DC_HIT), 32'h0, resp);
		check_resp("dcache clear bresp", perf_pkg::OKAY, resp);
		model[perf_pkg::EV_DC_HIT] = 0;
		pulse_event(perf_pkg::EV_DC_HIT, 300);
		check_all_counters("wrap");
	endtask

	initial
	begin
		checks        = 0;
		errors        = 0;
		timeouts      = 0;
		model_enable  = 1'b1;
		reset         = 1'b1;
		br_issue      = 1'b0;
		br_mispredict = 1'b0;
		stall         = 1'b0;
		icache_hit    = 1'b0;
		icache_miss   = 1'b0;
		dcache_hit    = 1'b0;
		dcache_miss   = 1'b0;
		l2_hit        = 1'b0;
		l2_miss       = 1'b0;
		awaddr        = '0;
		awvalid       = 1'b0;
		wdata         = '0;
		wstrb         = '0;
		wvalid        = 1'b0;
		bready        = 1'b0;
		araddr        = '0;
		arvalid       = 1'b0;
		rready        = 1'b0;
		for (int i = 0; i < perf_pkg::NUM_EVENTS; i++)
			model[i] = 0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		check_reset_values();
		count_cache_events();
		count_branches();
		clear_one_counter();
		toggle_enable();
		unmapped_and_wrap();

		$display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule : perf_monitor_tb

// File: perf_monitor_top.f
perf_pkg.sv
perf_event_counter.sv
perf_event_qualify.sv
perf_counter_bank.sv
perf_axil_fsm.sv
perf_monitor_top.sv
perf_monitor_tb.sv

// File: Makefile
SRCS = perf_pkg.sv perf_event_counter.sv perf_event_qualify.sv perf_counter_bank.sv \
	perf_axil_fsm.sv perf_monitor_top.sv perf_monitor_tb.sv

.PHONY: all run check clean

all: run

obj_dir/Vperf_monitor_tb: perf_monitor_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module perf_monitor_tb \
		-f perf_monitor_top.f

sim.log: obj_dir/Vperf_monitor_tb
	./obj_dir/Vperf_monitor_tb > sim.log 2>&1; st=$$?; cat sim.log; exit $$st

run: sim.log
	@! grep -q "Finished with errors" sim.log

check:
	@test -f sim.log
	@! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log
